// ==== capture/sample_capture.sv ====
`timescale 1ns/1ps

module sample_capture (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               adc_valid,
    input  logic [demod_pkg::SAMPLE_W-1:0]     adc_sample,
    sample_ram_if.writer                       ram,
    output logic                               frame_valid,
    input  logic                               frame_ready,
    output logic [demod_pkg::RING_ADDR_W-1:0]  detect_index
);

    logic [demod_pkg::RING_ADDR_W-1:0]  wr_addr;
    logic signed [demod_pkg::SAMPLE_W:0] centered;
    logic [demod_pkg::SAMPLE_W:0]       abs_full;
    logic [demod_pkg::SAMPLE_W-1:0]     mag;
    logic [demod_pkg::INTEG_W-1:0]      integral;
    logic [demod_pkg::INTEG_W:0]        integ_sum;
    logic [demod_pkg::FRAME_CNT_W-1:0]  count;

    // every sample goes straight into the ring
    assign ram.we = adc_valid;
    assign ram.waddr = wr_addr;
    assign ram.wdata = adc_sample;

    // distance from midpoint, small values treated as silence
    assign centered = $signed({1'b0, adc_sample}) - $signed(demod_pkg::MIDPOINT[demod_pkg::SAMPLE_W:0]);
    assign abs_full = centered[demod_pkg::SAMPLE_W] ? -centered : centered;
    assign mag = (abs_full < demod_pkg::NOISE_FLOOR) ? '0 : abs_full[demod_pkg::SAMPLE_W-1:0];
    assign integ_sum = {1'b0, integral} + {{(demod_pkg::INTEG_W+1-demod_pkg::SAMPLE_W){1'b0}}, mag};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (adc_valid) begin
            if (wr_addr == demod_pkg::RING_DEPTH - 1) begin
                wr_addr <= '0;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
            integral <= '0;
            count <= '0;
            detect_index <= '0;
        end else if (frame_valid && frame_ready) begin
            // frame taken, re-arm detection
            frame_valid <= 1'b0;
            integral <= '0;
            count <= '0;
        end else if (count == demod_pkg::FFT_N) begin
            frame_valid <= 1'b1;
        end else if (adc_valid) begin
            if (count == '0) begin
                if (integ_sum >= demod_pkg::DETECT_THRESHOLD) begin
                    detect_index <= wr_addr;
                    count <= 1;
                end else begin
                    integral <= integ_sum[demod_pkg::INTEG_W-1:0];
                end
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // sequencer may still be loading from this index
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid && !frame_ready |=> frame_valid && $stable(detect_index));

endmodule

// ==== capture/sample_ring.sv ====
`timescale 1ns/1ps

module sample_ring (
    input logic     clk,
    sample_ram_if.mem ram
);

    logic [demod_pkg::SAMPLE_W-1:0] mem [demod_pkg::RING_DEPTH];
    logic [demod_pkg::SAMPLE_W-1:0] rdata_q;

    // write port, capture side
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.waddr] <= ram.wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rdata_q <= mem[ram.raddr];
    end

    assign ram.rdata = rdata_q;

endmodule

// ==== common/demod_pkg.sv ====
package demod_pkg;

    // adc samples and the capture ring
    localparam int SAMPLE_W = 10;
    localparam int RING_DEPTH = 8192;
    localparam int RING_ADDR_W = 13;

    // signal detection
    localparam int MIDPOINT = 256;
    localparam int NOISE_FLOOR = 8;
    localparam int DETECT_THRESHOLD = 128;
    localparam int INTEG_W = 16;

    // fft window, real part in the upper half
    localparam int FFT_N = 1024;
    localparam int FFT_ADDR_W = 10;
    localparam int FRAME_CNT_W = 11;
    localparam int FFT_WORD_W = 32;
    localparam int FFT_HALF_W = 16;

    // decode retries
    localparam int SHIFT_MAX = 10;
    localparam int SHIFT_W = 4;

    // result byte stream
    localparam int RESULT_W = 96;
    localparam int RESULT_BYTES = 12;
    localparam int BYTE_W = 8;
    localparam int BYTE_CNT_W = 4;

    // sequencer states
    localparam int SEQ_W = 3;
    localparam logic [SEQ_W-1:0] SEQ_IDLE = 3'd0;
    localparam logic [SEQ_W-1:0] SEQ_LOAD = 3'd1;
    localparam logic [SEQ_W-1:0] SEQ_FFT = 3'd2;
    localparam logic [SEQ_W-1:0] SEQ_OFDM = 3'd3;
    localparam logic [SEQ_W-1:0] SEQ_SEND = 3'd4;
    localparam logic [SEQ_W-1:0] SEQ_RELEASE = 3'd5;

endpackage

// ==== common/sample_ram_if.sv ====
`timescale 1ns/1ps

interface sample_ram_if;

    logic                                we;
    logic [demod_pkg::RING_ADDR_W-1:0]   waddr;
    logic [demod_pkg::SAMPLE_W-1:0]      wdata;
    logic [demod_pkg::RING_ADDR_W-1:0]   raddr;
    logic [demod_pkg::SAMPLE_W-1:0]      rdata;

    // capture side
    modport writer (output we, output waddr, output wdata);

    // window loader side
    modport reader (output raddr, input rdata);

    modport mem (input we, input waddr, input wdata, input raddr, output rdata);

endinterface

// ==== demod.f ====
common/demod_pkg.sv
common/sample_ram_if.sv
capture/sample_ring.sv
capture/sample_capture.sv
src/window_loader.sv
src/demod_sequencer.sv
src/result_serializer.sv
src/demod_top.sv
dv/tb_demod_models.sv
dv/tb_demod.sv

// ==== dv/tb_demod.sv ====
`timescale 1ns/1ps

module tb_demod;

    logic                               clk;
    logic                               rst_n;
    logic                               adc_valid;
    logic [demod_pkg::SAMPLE_W-1:0]     adc_sample;
    logic                               fft_we;
    logic [demod_pkg::FFT_ADDR_W-1:0]   fft_addr;
    logic [demod_pkg::FFT_WORD_W-1:0]   fft_wdata;
    logic                               fft_start;
    logic                               fft_done;
    logic                               ofdm_start;
    logic                               ofdm_done;
    logic                               ofdm_success;
    logic [demod_pkg::RESULT_W-1:0]     ofdm_result;
    logic                               uart_valid;
    logic [demod_pkg::BYTE_W-1:0]       uart_data;
    logic                               uart_ready;
    logic                               loud = 1'b0;
    logic                               quiet = 1'b1;
    logic                               hold_check = 1'b0;
    logic [demod_pkg::BYTE_W-1:0]       held_data;
    logic [demod_pkg::FFT_N-1:0]        seen = '0;
    int write_count = 0;
    int load_count = 0;
    int byte_total = 0;
    int seed_ret;

    demod_top u_dut (.*);

    tb_demod_models u_models (.*);

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench check failed");
    endtask

    function automatic int bit_reverse(input logic [demod_pkg::FFT_ADDR_W-1:0] a);
        int r;
        r = 0;
        for (int i = 0; i < demod_pkg::FFT_ADDR_W; i++) begin
            r = r | (int'(a[i]) << (demod_pkg::FFT_ADDR_W - 1 - i));
        end
        return r;
    endfunction

    task automatic play_burst();
        loud = 1'b1;
        repeat (600 * 4) @(negedge clk);
        loud = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one sample every 4 cycles, noise stays inside the floor
    initial begin : adc_drive
        int amp;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (loud) begin
                amp = $urandom_range(200, 20);
                amp = $urandom_range(1, 0) ? amp : -amp;
            end else begin
                amp = int'($urandom_range(14, 0)) - 7;
            end
            adc_valid = 1'b1;
            adc_sample = demod_pkg::MIDPOINT + amp;
            @(negedge clk);
            adc_valid = 1'b0;
            repeat (2) @(negedge clk);
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            uart_ready = ($urandom_range(3, 0) != 0);
        end
    end

    // 3 frames, each a full window of samples plus every retry, 2x margin
    initial begin
        repeat (2 * 3 * (4 * demod_pkg::FFT_N + demod_pkg::SHIFT_MAX * (demod_pkg::FFT_N + 40)))
            @(posedge clk);
        $display("watchdog expired before all three frames were handled");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    assert property (@(posedge clk) disable iff (!rst_n) fft_start |-> !fft_we)
        else report_failure("fft_we still high in the cycle of fft_start");
    assert property (@(posedge clk) disable iff (!rst_n) uart_valid |-> ofdm_success)
        else report_failure("byte stream active for a frame that never decoded");

    always @(posedge clk) begin : monitor
        int addr;
        logic signed [demod_pkg::FFT_HALF_W-1:0] c;
        logic [demod_pkg::FFT_WORD_W-1:0] exp_word;
        logic [demod_pkg::BYTE_W-1:0] exp_byte;
        if (rst_n) begin
            if (quiet) begin
                assert (!fft_we && !fft_start && !ofdm_start && !uart_valid)
                    else report_failure("control output active while the input was quiet");
            end
            if (fft_we) begin
                // window base moves back one sample per failed attempt
                addr = (u_models.pred_index - u_models.shift + demod_pkg::RING_DEPTH
                        + bit_reverse(fft_addr)) % demod_pkg::RING_DEPTH;
                c = 16'(int'(u_models.history[addr]) - demod_pkg::MIDPOINT);
                exp_word = {c, 16'h0000};
                assert (fft_wdata == exp_word)
                    else report_failure($sformatf("mismatch at %0t fft_wdata expected 0x%08h got 0x%08h",
                                                  $time, exp_word, fft_wdata));
                assert (!seen[fft_addr])
                    else report_failure($sformatf("fft_addr %0d written twice in one load", fft_addr));
                seen[fft_addr] = 1'b1;
                write_count++;
            end
            if (fft_start) begin
                assert (write_count == demod_pkg::FFT_N)
                    else report_failure($sformatf("mismatch at %0t fft write count expected %0d got %0d",
                                                  $time, demod_pkg::FFT_N, write_count));
                write_count = 0;
                seen = '0;
                load_count++;
            end
            if (hold_check) begin
                assert (uart_valid && uart_data == held_data)
                    else report_failure($sformatf("mismatch at %0t uart_data expected 0x%02h got 0x%02h",
                                                  $time, held_data, uart_data));
            end
            hold_check = uart_valid && !uart_ready;
            held_data = uart_data;
            if (uart_valid && uart_ready) begin
                exp_byte = ofdm_result[8 * (byte_total % demod_pkg::RESULT_BYTES) +: 8];
                assert (uart_data == exp_byte)
                    else report_failure($sformatf("mismatch at %0t uart_data expected 0x%02h got 0x%02h",
                                                  $time, exp_byte, uart_data));
                byte_total++;
            end
        end
    end

    initial begin
        seed_ret = $urandom(5);
        rst_n = 1'b0;
        adc_valid = 1'b0;
        adc_sample = demod_pkg::MIDPOINT;
        uart_ready = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (1200) @(negedge clk);
        quiet = 1'b0;
        play_burst();
        wait (byte_total == demod_pkg::RESULT_BYTES);
        repeat (50) @(negedge clk);
        // second frame is dropped after every retry fails
        play_burst();
        wait (u_models.attempts == 3 + demod_pkg::SHIFT_MAX);
        repeat (50) @(negedge clk);
        play_burst();
        wait (byte_total == 2 * demod_pkg::RESULT_BYTES);
        repeat (50) @(negedge clk);
        if (load_count == 3 + demod_pkg::SHIFT_MAX + 1 && byte_total == 2 * demod_pkg::RESULT_BYTES) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure($sformatf("mismatch at %0t load_count expected %0d got %0d",
                                     $time, 3 + demod_pkg::SHIFT_MAX + 1, load_count));
        end
    end

endmodule

// ==== dv/tb_demod_models.sv ====
`timescale 1ns/1ps

module tb_demod_models (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               adc_valid,
    input  logic [demod_pkg::SAMPLE_W-1:0]     adc_sample,
    input  logic                               fft_start,
    input  logic                               ofdm_start,
    output logic                               fft_done,
    output logic                               ofdm_done,
    output logic                               ofdm_success,
    output logic [demod_pkg::RESULT_W-1:0]     ofdm_result
);

    logic [demod_pkg::SAMPLE_W-1:0] history [demod_pkg::RING_DEPTH];
    int wr_addr = 0;
    int integ = 0;
    int count = 0;
    int pred_index = 0;
    int shift = 0;
    int attempts = 0;

    // detection model, armed again once its window is complete
    always @(posedge clk) begin : track
        int mag;
        if (rst_n && adc_valid) begin
            mag = int'(adc_sample) - demod_pkg::MIDPOINT;
            mag = (mag < 0) ? -mag : mag;
            mag = (mag < demod_pkg::NOISE_FLOOR) ? 0 : mag;
            history[wr_addr] <= adc_sample;
            wr_addr <= (wr_addr + 1) % demod_pkg::RING_DEPTH;
            if (count == 0 && integ + mag >= demod_pkg::DETECT_THRESHOLD) begin
                pred_index <= wr_addr;
                count <= 1;
            end else if (count == 0) begin
                integ <= integ + mag;
            end else if (count == demod_pkg::FFT_N - 1) begin
                count <= 0;
                integ <= 0;
            end else begin
                count <= count + 1;
            end
        end
    end

    initial begin
        fft_done = 1'b0;
        forever begin
            @(posedge clk);
            if (fft_start) begin
                repeat ($urandom_range(20, 5) - 1) @(posedge clk);
                @(negedge clk);
                fft_done = 1'b1;
                @(negedge clk);
                fft_done = 1'b0;
            end
        end
    end

    // frame 1 decodes on its third try, frame 2 never, frame 3 at once
    initial begin
        ofdm_done = 1'b0;
        ofdm_success = 1'b0;
        ofdm_result = '0;
        forever begin
            @(posedge clk);
            if (ofdm_start) begin
                repeat ($urandom_range(8, 2)) @(posedge clk);
                @(negedge clk);
                ofdm_done = 1'b1;
                ofdm_success = (attempts == 2) || (attempts >= 13);
                ofdm_result = {$urandom, $urandom, $urandom};
                shift = (ofdm_success || shift == demod_pkg::SHIFT_MAX - 1) ? 0 : shift + 1;
                attempts = attempts + 1;
                @(negedge clk);
                ofdm_done = 1'b0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f demod.f --top-module tb_demod -o tb_demod &&
./obj_dir/tb_demod | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run passed" && exit 0 || { echo "run failed"; exit 1; }

// ==== src/demod_sequencer.sv ====
`timescale 1ns/1ps

module demod_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               frame_valid,
    output logic                               frame_ready,
    input  logic [demod_pkg::RING_ADDR_W-1:0]  detect_index,
    output logic                               load_start,
    output logic [demod_pkg::RING_ADDR_W-1:0]  load_base,
    input  logic                               load_done,
    output logic                               fft_start,
    input  logic                               fft_done,
    output logic                               ofdm_start,
    input  logic                               ofdm_done,
    input  logic                               ofdm_success,
    output logic                               send_start,
    input  logic                               send_done
);

    logic [demod_pkg::SEQ_W-1:0]         state;
    logic [demod_pkg::SHIFT_W-1:0]       shift_cnt;
    logic [demod_pkg::SHIFT_W-1:0]       shift_next;
    logic [demod_pkg::RING_ADDR_W-1:0]   shift_ext;
    logic [demod_pkg::RING_ADDR_W-1:0]   base_next;

    assign shift_next = shift_cnt + 1'b1;
    assign shift_ext = {{(demod_pkg::RING_ADDR_W-demod_pkg::SHIFT_W){1'b0}}, shift_next};

    // retry window one sample earlier, wraps below address 0
    assign base_next = detect_index - shift_ext;

    // held for one cycle, capture drops frame_valid after it
    assign frame_ready = (state == demod_pkg::SEQ_RELEASE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= demod_pkg::SEQ_IDLE;
            shift_cnt <= '0;
            load_start <= 1'b0;
            load_base <= '0;
            fft_start <= 1'b0;
            ofdm_start <= 1'b0;
            send_start <= 1'b0;
        end else begin
            load_start <= 1'b0;
            fft_start <= 1'b0;
            ofdm_start <= 1'b0;
            send_start <= 1'b0;
            case (state)
                demod_pkg::SEQ_IDLE: begin
                    if (frame_valid) begin
                        shift_cnt <= '0;
                        load_start <= 1'b1;
                        load_base <= detect_index;
                        state <= demod_pkg::SEQ_LOAD;
                    end
                end
                demod_pkg::SEQ_LOAD: begin
                    if (load_done) begin
                        fft_start <= 1'b1;
                        state <= demod_pkg::SEQ_FFT;
                    end
                end
                demod_pkg::SEQ_FFT: begin
                    if (fft_done) begin
                        ofdm_start <= 1'b1;
                        state <= demod_pkg::SEQ_OFDM;
                    end
                end
                demod_pkg::SEQ_OFDM: begin
                    if (ofdm_done) begin
                        if (ofdm_success) begin
                            send_start <= 1'b1;
                            state <= demod_pkg::SEQ_SEND;
                        end else if (shift_cnt == demod_pkg::SHIFT_MAX - 1) begin
                            // out of retries, drop the frame
                            state <= demod_pkg::SEQ_RELEASE;
                        end else begin
                            shift_cnt <= shift_next;
                            load_start <= 1'b1;
                            load_base <= base_next;
                            state <= demod_pkg::SEQ_LOAD;
                        end
                    end
                end
                demod_pkg::SEQ_SEND: begin
                    if (send_done) begin
                        state <= demod_pkg::SEQ_RELEASE;
                    end
                end
                default: begin
                    state <= demod_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) fft_done |-> state == demod_pkg::SEQ_FFT);
    assert property (@(posedge clk) disable iff (!rst_n) ofdm_done |-> state == demod_pkg::SEQ_OFDM);

endmodule

// ==== src/demod_top.sv ====
`timescale 1ns/1ps

module demod_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               adc_valid,
    input  logic [demod_pkg::SAMPLE_W-1:0]     adc_sample,
    output logic                               fft_we,
    output logic [demod_pkg::FFT_ADDR_W-1:0]   fft_addr,
    output logic [demod_pkg::FFT_WORD_W-1:0]   fft_wdata,
    output logic                               fft_start,
    input  logic                               fft_done,
    output logic                               ofdm_start,
    input  logic                               ofdm_done,
    input  logic                               ofdm_success,
    input  logic [demod_pkg::RESULT_W-1:0]     ofdm_result,
    output logic                               uart_valid,
    output logic [demod_pkg::BYTE_W-1:0]       uart_data,
    input  logic                               uart_ready
);

    logic                               frame_valid;
    logic                               frame_ready;
    logic [demod_pkg::RING_ADDR_W-1:0]  detect_index;
    logic                               load_start;
    logic [demod_pkg::RING_ADDR_W-1:0]  load_base;
    logic                               load_done;
    logic                               send_start;
    logic                               send_done;

    sample_ram_if ram ();

    sample_capture u_capture (
        .clk, .rst_n, .adc_valid, .adc_sample,
        .ram (ram.writer),
        .frame_valid, .frame_ready, .detect_index
    );

    sample_ring u_ring (
        .clk,
        .ram (ram.mem)
    );

    window_loader u_loader (
        .clk, .rst_n, .load_start, .load_base,
        .ram (ram.reader),
        .fft_we, .fft_addr, .fft_wdata, .load_done
    );

    demod_sequencer u_seq (
        .clk, .rst_n,
        .frame_valid, .frame_ready, .detect_index,
        .load_start, .load_base, .load_done,
        .fft_start, .fft_done,
        .ofdm_start, .ofdm_done, .ofdm_success,
        .send_start, .send_done
    );

    result_serializer u_ser (
        .clk, .rst_n, .send_start, .ofdm_result,
        .uart_valid, .uart_data, .uart_ready, .send_done
    );

endmodule

// ==== src/result_serializer.sv ====
`timescale 1ns/1ps

module result_serializer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              send_start,
    input  logic [demod_pkg::RESULT_W-1:0]    ofdm_result,
    output logic                              uart_valid,
    output logic [demod_pkg::BYTE_W-1:0]      uart_data,
    input  logic                              uart_ready,
    output logic                              send_done
);

    logic [demod_pkg::RESULT_W-1:0]    shreg;
    logic [demod_pkg::BYTE_CNT_W-1:0]  byte_idx;
    logic                              xfer;

    assign xfer = uart_valid && uart_ready;

    // lsb byte first
    assign uart_data = shreg[demod_pkg::BYTE_W-1:0];

    always_ff @(posedge clk) begin
        if (send_start) begin
            shreg <= ofdm_result;
        end else if (xfer) begin
            shreg <= shreg >> demod_pkg::BYTE_W;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_valid <= 1'b0;
            byte_idx <= '0;
            send_done <= 1'b0;
        end else begin
            send_done <= 1'b0;
            if (send_start) begin
                uart_valid <= 1'b1;
                byte_idx <= '0;
            end else if (xfer) begin
                if (byte_idx == demod_pkg::RESULT_BYTES - 1) begin
                    uart_valid <= 1'b0;
                    send_done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        uart_valid && !uart_ready |=> uart_valid && $stable(uart_data));

endmodule

// ==== src/window_loader.sv ====
`timescale 1ns/1ps

module window_loader (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load_start,
    input  logic [demod_pkg::RING_ADDR_W-1:0]  load_base,
    sample_ram_if.reader                       ram,
    output logic                               fft_we,
    output logic [demod_pkg::FFT_ADDR_W-1:0]   fft_addr,
    output logic [demod_pkg::FFT_WORD_W-1:0]   fft_wdata,
    output logic                               load_done
);

    logic                                issue;
    logic [demod_pkg::FFT_ADDR_W-1:0]    issue_off;
    logic                                rd_active;
    logic [demod_pkg::FFT_ADDR_W-1:0]    rd_off;
    logic [demod_pkg::RING_ADDR_W-1:0]   rd_ptr;
    logic                                p1_valid;
    logic                                p1_last;
    logic [demod_pkg::FFT_ADDR_W-1:0]    p1_off;
    logic [demod_pkg::FFT_ADDR_W-1:0]    p1_rev;
    logic signed [demod_pkg::SAMPLE_W:0] p1_centered;
    logic                                fft_last;

    // first read goes out in the start cycle itself
    assign issue = load_start || rd_active;
    assign issue_off = load_start ? '0 : rd_off;
    assign ram.raddr = load_start ? load_base : rd_ptr;

    always_comb begin
        for (int i = 0; i < demod_pkg::FFT_ADDR_W; i++) begin
            p1_rev[i] = p1_off[demod_pkg::FFT_ADDR_W-1-i];
        end
    end

    assign p1_centered = $signed({1'b0, ram.rdata}) - $signed(demod_pkg::MIDPOINT[demod_pkg::SAMPLE_W:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_off <= '0;
            rd_ptr <= '0;
            p1_valid <= 1'b0;
            p1_last <= 1'b0;
            fft_we <= 1'b0;
            fft_last <= 1'b0;
            load_done <= 1'b0;
        end else begin
            rd_active <= issue && (issue_off != demod_pkg::FFT_N - 1);
            if (issue) begin
                rd_off <= issue_off + 1'b1;
                rd_ptr <= (ram.raddr == demod_pkg::RING_DEPTH - 1) ? '0 : ram.raddr + 1'b1;
            end
            p1_valid <= issue;
            p1_last <= issue && (issue_off == demod_pkg::FFT_N - 1);
            fft_we <= p1_valid;
            fft_last <= p1_last;
            load_done <= fft_last;
        end
    end

    // payload stage, real = centered sample, imag = 0
    always_ff @(posedge clk) begin
        p1_off <= issue_off;
        fft_addr <= p1_rev;
        fft_wdata <= {{(demod_pkg::FFT_HALF_W-demod_pkg::SAMPLE_W-1){p1_centered[demod_pkg::SAMPLE_W]}},
                      p1_centered, {demod_pkg::FFT_HALF_W{1'b0}}};
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        load_start |-> !(rd_active || p1_valid || fft_we));

endmodule
